//--- design/exu_pkg.sv
`default_nettype none

package exu_pkg;

	localparam int xlen           = 32;
	localparam int bus_width      = 64;
	localparam int strb_width     = bus_width / 8;
	localparam int reg_addr_width = 5;
	localparam int beat_bytes     = 8;
	localparam int link_offset    = 4;

	// compare ops return 1 or 0 in bit 0
	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor,
		alu_sll, alu_srl, alu_sra,
		alu_slt, alu_sltu, alu_seq, alu_sne, alu_sge, alu_sgeu
	} alu_op_t;

	typedef enum logic [3:0] {
		mem_none,
		mem_lw, mem_lh, mem_lhu, mem_lb, mem_lbu,
		mem_sw, mem_sh, mem_sb
	} mem_op_t;

	typedef enum logic [1:0] {
		jump_none, jump_jal, jump_jalr
	} jump_t;

	// second read only for loads crossing a beat boundary
	typedef enum logic [2:0] {
		rd_idle, rd_addr, rd_data, rd_addr2, rd_data2, rd_done
	} rd_state_t;

	typedef enum logic [2:0] {
		wr_idle, wr_addr, wr_data, wr_resp, wr_done
	} wr_state_t;

endpackage

`default_nettype wire

//--- design/exu_alu.sv
`default_nettype none

module exu_alu import exu_pkg::*; (
	input  alu_op_t         alu_op,
	input  logic [xlen-1:0] src1,
	input  logic [xlen-1:0] src2,
	output logic [xlen-1:0] alu_result
);

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = src2[4:0];
	assign lt_signed   = $signed(src1) < $signed(src2);
	assign lt_unsigned = src1 < src2;

	always_comb begin
		alu_result = '0;
		case (alu_op)
			alu_add:  alu_result = src1 + src2;
			alu_sub:  alu_result = src1 - src2;
			alu_and:  alu_result = src1 & src2;
			alu_or:   alu_result = src1 | src2;
			alu_xor:  alu_result = src1 ^ src2;
			alu_sll:  alu_result = src1 << shamt;
			alu_srl:  alu_result = src1 >> shamt;
			alu_sra:  alu_result = $unsigned($signed(src1) >>> shamt);
			// compares land in bit 0, branch logic reads that bit
			alu_slt:  alu_result[0] = lt_signed;
			alu_sltu: alu_result[0] = lt_unsigned;
			alu_seq:  alu_result[0] = (src1 == src2);
			alu_sne:  alu_result[0] = (src1 != src2);
			alu_sge:  alu_result[0] = !lt_signed;
			alu_sgeu: alu_result[0] = !lt_unsigned;
			default:  alu_result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- design/exu_ctrl.sv
`default_nettype none

module exu_ctrl import exu_pkg::*; (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      in_valid,
	input  alu_op_t                   in_alu_op,
	input  logic [xlen-1:0]           in_src1,
	input  logic [xlen-1:0]           in_src2,
	input  logic [reg_addr_width-1:0] in_rd,
	input  mem_op_t                   in_mem_op,
	input  logic [xlen-1:0]           in_store_data,
	input  jump_t                     in_jump,
	input  logic                      in_branch,
	input  logic [xlen-1:0]           in_branch_target,
	input  logic [xlen-1:0]           in_pc,
	input  logic                      in_wb_en,
	input  logic                      need_second,
	input  logic                      dmem_arready,
	input  logic                      dmem_rvalid,
	input  logic                      dmem_awready,
	input  logic                      dmem_wready,
	input  logic                      dmem_bvalid,
	output logic                      allowin,
	output logic                      complete,
	output alu_op_t                   alu_op,
	output logic [xlen-1:0]           src1,
	output logic [xlen-1:0]           src2,
	output logic [reg_addr_width-1:0] rd,
	output mem_op_t                   mem_op,
	output logic [xlen-1:0]           store_data,
	output jump_t                     jump,
	output logic                      branch,
	output logic [xlen-1:0]           branch_target,
	output logic [xlen-1:0]           pc,
	output logic                      wb_en,
	output logic                      rd_second,
	output logic                      beat_capture,
	output logic                      dmem_arvalid,
	output logic                      dmem_rready,
	output logic                      dmem_awvalid,
	output logic                      dmem_wvalid,
	output logic                      dmem_bready
);

	logic      stage_valid;
	logic      accept;
	logic      is_load;
	logic      is_store;
	logic      in_is_load;
	logic      in_is_store;
	rd_state_t rd_state;
	rd_state_t rd_next;
	wr_state_t wr_state;
	wr_state_t wr_next;

	assign in_is_load  = in_mem_op inside {mem_lw, mem_lh, mem_lhu, mem_lb, mem_lbu};
	assign in_is_store = in_mem_op inside {mem_sw, mem_sh, mem_sb};
	assign is_load     = mem_op inside {mem_lw, mem_lh, mem_lhu, mem_lb, mem_lbu};
	assign is_store    = mem_op inside {mem_sw, mem_sh, mem_sb};

	// memory ops finish in their done state, everything else one cycle in
	always_comb begin
		if (is_load)
			complete = stage_valid && (rd_state == rd_done);
		else if (is_store)
			complete = stage_valid && (wr_state == wr_done);
		else
			complete = stage_valid;
	end

	assign allowin = !stage_valid || complete;
	assign accept  = in_valid && allowin;

	always_ff @(posedge clock) begin
		if (reset)
			stage_valid <= 1'b0;
		else if (allowin)
			stage_valid <= in_valid;
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			alu_op        <= in_alu_op;
			src1          <= in_src1;
			src2          <= in_src2;
			rd            <= in_rd;
			mem_op        <= in_mem_op;
			store_data    <= in_store_data;
			jump          <= in_jump;
			branch        <= in_branch;
			branch_target <= in_branch_target;
			pc            <= in_pc;
			wb_en         <= in_wb_en;
		end
	end

	// machines start on the accepting edge, no idle cycle in between
	always_comb begin
		case (rd_state)
			rd_idle, rd_done: rd_next = (accept && in_is_load) ? rd_addr : rd_idle;
			rd_addr:  rd_next = dmem_arready ? rd_data : rd_addr;
			rd_data: begin
				if (!dmem_rvalid)
					rd_next = rd_data;
				else
					rd_next = need_second ? rd_addr2 : rd_done;
			end
			rd_addr2: rd_next = dmem_arready ? rd_data2 : rd_addr2;
			rd_data2: rd_next = dmem_rvalid ? rd_done : rd_data2;
			default:  rd_next = rd_idle;
		endcase
	end

	always_comb begin
		case (wr_state)
			wr_idle, wr_done: wr_next = (accept && in_is_store) ? wr_addr : wr_idle;
			wr_addr: wr_next = dmem_awready ? wr_data : wr_addr;
			wr_data: wr_next = dmem_wready ? wr_resp : wr_data;
			wr_resp: wr_next = dmem_bvalid ? wr_done : wr_resp;
			default: wr_next = wr_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_state <= rd_idle;
			wr_state <= wr_idle;
		end else begin
			rd_state <= rd_next;
			wr_state <= wr_next;
		end
	end

	assign dmem_arvalid = (rd_state == rd_addr) || (rd_state == rd_addr2);
	assign dmem_rready  = (rd_state == rd_data) || (rd_state == rd_data2);
	assign beat_capture = dmem_rready && dmem_rvalid;
	assign rd_second    = (rd_state == rd_addr2) || (rd_state == rd_data2);
	assign dmem_awvalid = (wr_state == wr_addr);
	assign dmem_wvalid  = (wr_state == wr_data);
	assign dmem_bready  = (wr_state == wr_resp);

endmodule

`default_nettype wire

//--- design/exu_dmem_path.sv
`default_nettype none

module exu_dmem_path import exu_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  mem_op_t               mem_op,
	input  logic [xlen-1:0]       alu_result,
	input  logic [xlen-1:0]       store_data,
	input  logic                  rd_second,
	input  logic                  beat_capture,
	input  logic [bus_width-1:0]  dmem_rdata,
	output logic [xlen-1:0]       dmem_araddr,
	output logic [xlen-1:0]       dmem_awaddr,
	output logic [bus_width-1:0]  dmem_wdata,
	output logic [strb_width-1:0] dmem_wstrb,
	output logic                  need_second,
	output logic [xlen-1:0]       load_data
);

	logic [2:0]             offset;
	logic [xlen-1:0]        base_addr;
	logic [bus_width-1:0]   beat0;
	logic [bus_width-1:0]   beat1;
	logic [2*bus_width-1:0] shifted;
	logic [xlen-1:0]        word;

	assign offset    = alu_result[2:0];
	assign base_addr = {alu_result[xlen-1:3], 3'b000};

	// second beat is the next aligned address
	assign dmem_araddr = rd_second ? base_addr + xlen'(beat_bytes) : base_addr;
	assign dmem_awaddr = alu_result;
	assign dmem_wdata  = {store_data, store_data};

	always_comb begin
		case (mem_op)
			mem_sw:  dmem_wstrb = 8'h0f;
			mem_sh:  dmem_wstrb = 8'h03;
			mem_sb:  dmem_wstrb = 8'h01;
			default: dmem_wstrb = '0;
		endcase
	end

	// bytes past offset 7 live in the next beat
	always_comb begin
		case (mem_op)
			mem_lw:          need_second = (offset >= 3'd5);
			mem_lh, mem_lhu: need_second = (offset == 3'd7);
			default:         need_second = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			beat0 <= '0;
			beat1 <= '0;
		end else if (beat_capture) begin
			if (rd_second)
				beat1 <= dmem_rdata;
			else
				beat0 <= dmem_rdata;
		end
	end

	// beat1 only matters when the load spans both beats
	assign shifted = {beat1, beat0} >> {offset, 3'b000};
	assign word    = shifted[xlen-1:0];

	always_comb begin
		case (mem_op)
			mem_lh:  load_data = {{16{word[15]}}, word[15:0]};
			mem_lhu: load_data = {16'd0, word[15:0]};
			mem_lb:  load_data = {{24{word[7]}}, word[7:0]};
			mem_lbu: load_data = {24'd0, word[7:0]};
			default: load_data = word;
		endcase
	end

endmodule

`default_nettype wire

//--- design/exu_result.sv
`default_nettype none

module exu_result import exu_pkg::*; (
	input  logic                      complete,
	input  jump_t                     jump,
	input  logic                      branch,
	input  logic [xlen-1:0]           branch_target,
	input  logic [xlen-1:0]           pc,
	input  logic [xlen-1:0]           alu_result,
	input  logic [xlen-1:0]           load_data,
	input  mem_op_t                   mem_op,
	input  logic [reg_addr_width-1:0] rd,
	input  logic                      wb_en,
	output logic                      redirect_valid,
	output logic [xlen-1:0]           redirect_pc,
	output logic                      regfile_wen,
	output logic [reg_addr_width-1:0] regfile_waddr,
	output logic [xlen-1:0]           regfile_wdata
);

	logic branch_taken;
	logic is_load;

	// the compare result sits in bit 0
	assign branch_taken = branch && alu_result[0];
	assign is_load      = mem_op inside {mem_lw, mem_lh, mem_lhu, mem_lb, mem_lbu};

	always_comb begin
		case (jump)
			jump_jal:  redirect_pc = alu_result;
			jump_jalr: redirect_pc = {alu_result[xlen-1:1], 1'b0};
			default:   redirect_pc = branch_target;
		endcase
	end

	assign redirect_valid = complete && ((jump != jump_none) || branch_taken);

	assign regfile_wen   = complete && wb_en;
	assign regfile_waddr = rd;
	assign regfile_wdata = (jump != jump_none) ? pc + xlen'(link_offset) :
	                       is_load             ? load_data :
	                                             alu_result;

endmodule

`default_nettype wire

//--- design/exu_top.sv
`default_nettype none

module exu_top import exu_pkg::*; (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      in_valid,
	input  alu_op_t                   in_alu_op,
	input  logic [xlen-1:0]           in_src1,
	input  logic [xlen-1:0]           in_src2,
	input  logic [reg_addr_width-1:0] in_rd,
	input  mem_op_t                   in_mem_op,
	input  logic [xlen-1:0]           in_store_data,
	input  jump_t                     in_jump,
	input  logic                      in_branch,
	input  logic [xlen-1:0]           in_branch_target,
	input  logic [xlen-1:0]           in_pc,
	input  logic                      in_wb_en,
	input  logic                      dmem_arready,
	input  logic                      dmem_rvalid,
	input  logic [bus_width-1:0]      dmem_rdata,
	input  logic                      dmem_awready,
	input  logic                      dmem_wready,
	input  logic                      dmem_bvalid,
	output logic                      allowin,
	output logic                      done_valid,
	output logic                      redirect_valid,
	output logic [xlen-1:0]           redirect_pc,
	output logic                      regfile_wen,
	output logic [reg_addr_width-1:0] regfile_waddr,
	output logic [xlen-1:0]           regfile_wdata,
	output logic                      dmem_arvalid,
	output logic [xlen-1:0]           dmem_araddr,
	output logic                      dmem_rready,
	output logic                      dmem_awvalid,
	output logic [xlen-1:0]           dmem_awaddr,
	output logic                      dmem_wvalid,
	output logic [bus_width-1:0]      dmem_wdata,
	output logic [strb_width-1:0]     dmem_wstrb,
	output logic                      dmem_bready
);

	// issued operation, held by the control block
	alu_op_t                   alu_op;
	logic [xlen-1:0]           src1;
	logic [xlen-1:0]           src2;
	logic [reg_addr_width-1:0] rd;
	mem_op_t                   mem_op;
	logic [xlen-1:0]           store_data;
	jump_t                     jump;
	logic                      branch;
	logic [xlen-1:0]           branch_target;
	logic [xlen-1:0]           pc;
	logic                      wb_en;
	logic                      complete;
	logic                      rd_second;
	logic                      beat_capture;
	logic                      need_second;
	logic [xlen-1:0]           alu_result;
	logic [xlen-1:0]           load_data;

	assign done_valid = complete;

	exu_ctrl u_exu_ctrl (
		.clock            (clock),
		.reset            (reset),
		.in_valid         (in_valid),
		.in_alu_op        (in_alu_op),
		.in_src1          (in_src1),
		.in_src2          (in_src2),
		.in_rd            (in_rd),
		.in_mem_op        (in_mem_op),
		.in_store_data    (in_store_data),
		.in_jump          (in_jump),
		.in_branch        (in_branch),
		.in_branch_target (in_branch_target),
		.in_pc            (in_pc),
		.in_wb_en         (in_wb_en),
		.need_second      (need_second),
		.dmem_arready     (dmem_arready),
		.dmem_rvalid      (dmem_rvalid),
		.dmem_awready     (dmem_awready),
		.dmem_wready      (dmem_wready),
		.dmem_bvalid      (dmem_bvalid),
		.allowin          (allowin),
		.complete         (complete),
		.alu_op           (alu_op),
		.src1             (src1),
		.src2             (src2),
		.rd               (rd),
		.mem_op           (mem_op),
		.store_data       (store_data),
		.jump             (jump),
		.branch           (branch),
		.branch_target    (branch_target),
		.pc               (pc),
		.wb_en            (wb_en),
		.rd_second        (rd_second),
		.beat_capture     (beat_capture),
		.dmem_arvalid     (dmem_arvalid),
		.dmem_rready      (dmem_rready),
		.dmem_awvalid     (dmem_awvalid),
		.dmem_wvalid      (dmem_wvalid),
		.dmem_bready      (dmem_bready)
	);

	exu_alu u_exu_alu (
		.alu_op     (alu_op),
		.src1       (src1),
		.src2       (src2),
		.alu_result (alu_result)
	);

	exu_dmem_path u_exu_dmem_path (
		.clock        (clock),
		.reset        (reset),
		.mem_op       (mem_op),
		.alu_result   (alu_result),
		.store_data   (store_data),
		.rd_second    (rd_second),
		.beat_capture (beat_capture),
		.dmem_rdata   (dmem_rdata),
		.dmem_araddr  (dmem_araddr),
		.dmem_awaddr  (dmem_awaddr),
		.dmem_wdata   (dmem_wdata),
		.dmem_wstrb   (dmem_wstrb),
		.need_second  (need_second),
		.load_data    (load_data)
	);

	exu_result u_exu_result (
		.complete       (complete),
		.jump           (jump),
		.branch         (branch),
		.branch_target  (branch_target),
		.pc             (pc),
		.alu_result     (alu_result),
		.load_data      (load_data),
		.mem_op         (mem_op),
		.rd             (rd),
		.wb_en          (wb_en),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.regfile_wen    (regfile_wen),
		.regfile_waddr  (regfile_waddr),
		.regfile_wdata  (regfile_wdata)
	);

endmodule

`default_nettype wire

//--- verif/exu_assertions.sv
`default_nettype none

module exu_assertions import exu_pkg::*; (
	input logic            clock,
	input logic            reset,
	input logic            dmem_arvalid,
	input logic            dmem_arready,
	input logic [xlen-1:0] dmem_araddr,
	input logic            dmem_awvalid,
	input logic            dmem_awready,
	input logic [xlen-1:0] dmem_awaddr,
	input logic            dmem_wvalid,
	input logic            done_valid,
	input logic            regfile_wen,
	input logic            redirect_valid
);

	int ar_hold_fails = 0;
	int aw_hold_fails = 0;
	int w_order_fails = 0;
	int qual_fails    = 0;
	int fail_total;

	assign fail_total = ar_hold_fails + aw_hold_fails + w_order_fails + qual_fails;

	// a stalled request keeps its address until taken
	ar_hold: assert property (@(posedge clock) disable iff (reset)
		dmem_arvalid && !dmem_arready |=> dmem_arvalid && $stable(dmem_araddr))
		else begin
			ar_hold_fails++;
			$error("read request dropped or changed before acceptance");
		end

	aw_hold: assert property (@(posedge clock) disable iff (reset)
		dmem_awvalid && !dmem_awready |=> dmem_awvalid && $stable(dmem_awaddr))
		else begin
			aw_hold_fails++;
			$error("write request dropped or changed before acceptance");
		end

	// write data follows the address handshake
	w_order: assert property (@(posedge clock) disable iff (reset)
		$rose(dmem_wvalid) |-> $past(dmem_awvalid && dmem_awready))
		else begin
			w_order_fails++;
			$error("write data raised without a prior address handshake");
		end

	out_qual: assert property (@(posedge clock) disable iff (reset)
		(regfile_wen || redirect_valid) |-> done_valid)
		else begin
			qual_fails++;
			$error("register write or redirect outside of done_valid");
		end

endmodule

bind exu_top exu_assertions u_exu_assertions (.*);

`default_nettype wire

//--- verif/exu_tb.sv
`default_nettype none

module exu_tb import exu_pkg::*; ();

	localparam int num_ops        = 400;
	localparam int timeout_cycles = num_ops * 40;

	logic                      clock;
	logic                      reset;
	logic                      in_valid;
	alu_op_t                   in_alu_op;
	logic [xlen-1:0]           in_src1;
	logic [xlen-1:0]           in_src2;
	logic [reg_addr_width-1:0] in_rd;
	mem_op_t                   in_mem_op;
	logic [xlen-1:0]           in_store_data;
	jump_t                     in_jump;
	logic                      in_branch;
	logic [xlen-1:0]           in_branch_target;
	logic [xlen-1:0]           in_pc;
	logic                      in_wb_en;
	logic                      dmem_arready;
	logic                      dmem_rvalid;
	logic [bus_width-1:0]      dmem_rdata;
	logic                      dmem_awready;
	logic                      dmem_wready;
	logic                      dmem_bvalid;
	logic                      allowin;
	logic                      done_valid;
	logic                      redirect_valid;
	logic [xlen-1:0]           redirect_pc;
	logic                      regfile_wen;
	logic [reg_addr_width-1:0] regfile_waddr;
	logic [xlen-1:0]           regfile_wdata;
	logic                      dmem_arvalid;
	logic [xlen-1:0]           dmem_araddr;
	logic                      dmem_rready;
	logic                      dmem_awvalid;
	logic [xlen-1:0]           dmem_awaddr;
	logic                      dmem_wvalid;
	logic [bus_width-1:0]      dmem_wdata;
	logic [strb_width-1:0]     dmem_wstrb;
	logic                      dmem_bready;

	// what one accepted operation should do on the bus and at completion
	typedef struct packed {
		logic [2:0]  kind;
		logic        wen;
		logic [4:0]  waddr;
		logic [31:0] wdata;
		logic        redirect;
		logic [31:0] target;
		logic [1:0]  reads;
		logic [31:0] raddr;
		logic        store;
		logic [31:0] awaddr;
		logic [63:0] st_data;
		logic [7:0]  strb;
	} expect_t;

	expect_t    exp_q[$];
	logic [7:0] mem [0:63];
	logic [7:0] model_mem [0:63];

	int          cur_kind;
	logic        issue_taken;
	int          issued;
	int          completed;
	int          mismatches;
	int          other_errors;
	int          assert_fails;
	int          cycle_count;
	int          ar_seen;
	int          aw_seen;
	int          w_seen;
	int          ar_delay;
	int          aw_delay;
	int          w_delay;
	int          r_delay;
	int          b_delay;
	logic        r_pending;
	logic        b_pending;
	logic        done_due;
	logic [31:0] r_addr;
	logic [31:0] wr_addr;

	exu_top u_exu_top (.*);

	always #20 clock = ~clock;

	function automatic string kind_name(logic [2:0] kind);
		case (kind)
			3'd0:    return "alu";
			3'd1:    return "jal";
			3'd2:    return "jalr";
			3'd3:    return "branch";
			3'd4:    return "load";
			default: return "store";
		endcase
	endfunction

	function automatic logic [31:0] ref_alu(alu_op_t op, logic [31:0] a, logic [31:0] b);
		logic [4:0] sh;
		sh = b[4:0];
		case (op)
			alu_add:  return a + b;
			alu_sub:  return a - b;
			alu_and:  return a & b;
			alu_or:   return a | b;
			alu_xor:  return a ^ b;
			alu_sll:  return a << sh;
			alu_srl:  return a >> sh;
			alu_sra:  return 32'($signed(a) >>> sh);
			alu_slt:  return {31'd0, $signed(a) < $signed(b)};
			alu_sltu: return {31'd0, a < b};
			alu_seq:  return {31'd0, a == b};
			alu_sne:  return {31'd0, a != b};
			alu_sge:  return {31'd0, !($signed(a) < $signed(b))};
			alu_sgeu: return {31'd0, !(a < b)};
			default:  return 32'd0;
		endcase
	endfunction

	function automatic int mem_size(mem_op_t op);
		case (op)
			mem_lw, mem_sw:          return 4;
			mem_lh, mem_lhu, mem_sh: return 2;
			mem_lb, mem_lbu, mem_sb: return 1;
			default:                 return 0;
		endcase
	endfunction

	// little-endian bytes from the model with addresses wrapping at 64
	function automatic logic [31:0] load_model(mem_op_t op, logic [31:0] addr);
		logic [31:0] w;
		for (int i = 0; i < 4; i++)
			w[8*i +: 8] = model_mem[6'(addr + 32'(i))];
		case (op)
			mem_lh:  return {{16{w[15]}}, w[15:0]};
			mem_lhu: return {16'd0, w[15:0]};
			mem_lb:  return {{24{w[7]}}, w[7:0]};
			mem_lbu: return {24'd0, w[7:0]};
			default: return w;
		endcase
	endfunction

	task automatic report_mismatch(string test, string field, logic [63:0] exp,
			logic [63:0] act);
		mismatches++;
		$display("Mismatch %s %s: expected %h, actual %h", test, field, exp, act);
	endtask

	task automatic make_op();
		cur_kind         = $urandom % 6;
		in_alu_op        = alu_add;
		in_src1          = $urandom;
		in_src2          = $urandom;
		in_rd            = 5'($urandom);
		in_mem_op        = mem_none;
		in_store_data    = $urandom;
		in_jump          = jump_none;
		in_branch        = 1'b0;
		in_branch_target = $urandom & 32'hffff_fffc;
		in_pc            = $urandom & 32'hffff_fffc;
		in_wb_en         = 1'b1;
		case (cur_kind)
			0: begin
				in_alu_op = alu_op_t'(4'($urandom % 14));
				in_wb_en  = ($urandom % 8) != 0;
			end
			1: begin
				in_jump = jump_jal;
				in_src1 = in_pc;
				in_src2 = $urandom & 32'h0000_0ffe;
			end
			2: begin
				in_jump = jump_jalr;
				in_src2 = $urandom & 32'h0000_0fff;
			end
			3: begin
				// small signed operands so equal and negative cases show up
				in_alu_op = alu_op_t'(4'(8 + $urandom % 6));
				in_branch = 1'b1;
				in_src1   = 32'($signed(4'($urandom)));
				in_src2   = 32'($signed(4'($urandom)));
				in_wb_en  = 1'b0;
			end
			4: begin
				in_mem_op = mem_op_t'(4'(1 + $urandom % 5));
				in_src1   = $urandom & 32'h38;
				in_src2   = $urandom & 32'h7;
			end
			default: begin
				in_mem_op = mem_op_t'(4'(6 + $urandom % 3));
				in_src1   = $urandom & 32'h38;
				in_src2   = $urandom & 32'h7;
				in_wb_en  = 1'b0;
			end
		endcase
	endtask

	task automatic record_expected();
		expect_t     e;
		logic [31:0] res;
		int          size;
		e       = '0;
		res     = ref_alu(in_alu_op, in_src1, in_src2);
		size    = mem_size(in_mem_op);
		e.kind  = 3'(cur_kind);
		e.wen   = in_wb_en;
		e.waddr = in_rd;
		e.wdata = res;
		if (in_jump != jump_none) begin
			e.redirect = 1'b1;
			e.target   = (in_jump == jump_jalr) ? (res & ~32'd1) : res;
			e.wdata    = in_pc + 32'd4;
		end else if (in_branch) begin
			e.redirect = res[0];
			e.target   = in_branch_target;
		end
		if (in_mem_op inside {mem_lw, mem_lh, mem_lhu, mem_lb, mem_lbu}) begin
			e.wdata = load_model(in_mem_op, res);
			// a second beat only when the bytes run past the 8-byte line
			e.reads = (int'(res[2:0]) + size > 8) ? 2'd2 : 2'd1;
			e.raddr = res & ~32'd7;
		end else if (size != 0) begin
			e.store   = 1'b1;
			e.awaddr  = res;
			e.st_data = {in_store_data, in_store_data};
			e.strb    = 8'((1 << size) - 1);
			for (int i = 0; i < size; i++)
				model_mem[6'(res + 32'(i))] = in_store_data[8*i +: 8];
		end
		exp_q.push_back(e);
	endtask

	task automatic check_done();
		expect_t e;
		string   name;
		if (exp_q.size() == 0) begin
			other_errors++;
			$display("done_valid raised with no operation outstanding");
		end else begin
			e    = exp_q.pop_front();
			name = kind_name(e.kind);
			if (regfile_wen !== e.wen)
				report_mismatch(name, "regfile_wen", 64'(e.wen), 64'(regfile_wen));
			if (e.wen && regfile_waddr !== e.waddr)
				report_mismatch(name, "regfile_waddr", 64'(e.waddr), 64'(regfile_waddr));
			if (e.wen && regfile_wdata !== e.wdata)
				report_mismatch(name, "regfile_wdata", 64'(e.wdata), 64'(regfile_wdata));
			if (redirect_valid !== e.redirect)
				report_mismatch(name, "redirect_valid", 64'(e.redirect), 64'(redirect_valid));
			if (e.redirect && redirect_pc !== e.target)
				report_mismatch(name, "redirect_pc", 64'(e.target), 64'(redirect_pc));
			if (ar_seen != int'(e.reads))
				report_mismatch(name, "read count", 64'(e.reads), 64'(ar_seen));
			if (aw_seen != (e.store ? 1 : 0))
				report_mismatch(name, "write address count", 64'(e.store), 64'(aw_seen));
			if (w_seen != (e.store ? 1 : 0))
				report_mismatch(name, "write data count", 64'(e.store), 64'(w_seen));
			completed++;
		end
		ar_seen = 0;
		aw_seen = 0;
		w_seen  = 0;
	endtask

	task automatic drive_bus();
		dmem_arready = (ar_delay == 0);
		dmem_awready = (aw_delay == 0);
		dmem_wready  = (w_delay == 0);
		dmem_rvalid  = r_pending && (r_delay == 0);
		dmem_bvalid  = b_pending && (b_delay == 0);
		for (int i = 0; i < 8; i++)
			dmem_rdata[8*i +: 8] = mem[6'(r_addr + 32'(i))];
	endtask

	task automatic drive_issue();
		if (!in_valid || issue_taken) begin
			issue_taken = 1'b0;
			if (issued < num_ops && ($urandom % 4) != 0) begin
				make_op();
				in_valid = 1'b1;
			end else begin
				in_valid = 1'b0;
			end
		end
	endtask

	// everything seen here is what the next rising edge will sample
	task automatic observe();
		expect_t     head;
		logic [31:0] exp_raddr;
		logic        exp_done;
		logic        exp_allowin;
		string       name;
		if (exp_q.size() != 0) begin
			head = exp_q[0];
			name = kind_name(head.kind);
		end else begin
			head = '0;
			name = "idle";
		end
		// the stage finishes one cycle after a plain op is taken or its last beat or response
		exp_done    = done_due;
		exp_allowin = (exp_q.size() == 0) || exp_done;
		done_due    = 1'b0;
		if (done_valid !== exp_done)
			report_mismatch(name, "done_valid", 64'(exp_done), 64'(done_valid));
		if (allowin !== exp_allowin)
			report_mismatch(name, "allowin", 64'(exp_allowin), 64'(allowin));
		if (dmem_rvalid && dmem_rready) begin
			r_pending = 1'b0;
			if (ar_seen >= int'(head.reads))
				done_due = 1'b1;
		end else if (r_pending && r_delay > 0) begin
			r_delay--;
		end
		if (dmem_arvalid && dmem_arready) begin
			exp_raddr = head.raddr + 32'(ar_seen * beat_bytes);
			if (ar_seen >= int'(head.reads)) begin
				other_errors++;
				$display("unexpected read request at address %h", dmem_araddr);
			end else if (dmem_araddr !== exp_raddr) begin
				report_mismatch(kind_name(head.kind), "read address", 64'(exp_raddr),
					64'(dmem_araddr));
			end
			r_pending = 1'b1;
			r_addr    = dmem_araddr;
			r_delay   = $urandom % 4;
			ar_delay  = $urandom % 4;
			ar_seen++;
		end else if (dmem_arvalid && ar_delay > 0) begin
			ar_delay--;
		end
		if (dmem_bvalid && dmem_bready) begin
			b_pending = 1'b0;
			done_due  = 1'b1;
		end else if (b_pending && b_delay > 0) begin
			b_delay--;
		end
		if (dmem_awvalid && dmem_awready) begin
			if (!head.store) begin
				other_errors++;
				$display("unexpected write request at address %h", dmem_awaddr);
			end else if (dmem_awaddr !== head.awaddr) begin
				report_mismatch("store", "write address", 64'(head.awaddr), 64'(dmem_awaddr));
			end
			wr_addr  = dmem_awaddr;
			aw_delay = $urandom % 4;
			aw_seen++;
		end else if (dmem_awvalid && aw_delay > 0) begin
			aw_delay--;
		end
		if (dmem_wvalid && dmem_wready) begin
			if (!head.store) begin
				other_errors++;
				$display("unexpected write data beat");
			end else begin
				if (dmem_wdata !== head.st_data)
					report_mismatch("store", "write data", head.st_data, dmem_wdata);
				if (dmem_wstrb !== head.strb)
					report_mismatch("store", "write strobe", 64'(head.strb), 64'(dmem_wstrb));
			end
			for (int i = 0; i < 4; i++)
				if (dmem_wstrb[i])
					mem[6'(wr_addr + 32'(i))] = dmem_wdata[8*i +: 8];
			b_pending = 1'b1;
			b_delay   = $urandom % 4;
			w_delay   = $urandom % 4;
			w_seen++;
		end else if (dmem_wvalid && w_delay > 0) begin
			w_delay--;
		end
		if (done_valid)
			check_done();
		if (in_valid && allowin) begin
			record_expected();
			if (in_mem_op == mem_none)
				done_due = 1'b1;
			issued++;
			issue_taken = 1'b1;
		end
	endtask

	initial begin
		int rnd;
		rnd              = $urandom(32'h93a5fa7b);
		clock            = 1'b0;
		reset            = 1'b1;
		in_valid         = 1'b0;
		in_alu_op        = alu_add;
		in_src1          = '0;
		in_src2          = '0;
		in_rd            = '0;
		in_mem_op        = mem_none;
		in_store_data    = '0;
		in_jump          = jump_none;
		in_branch        = 1'b0;
		in_branch_target = '0;
		in_pc            = '0;
		in_wb_en         = 1'b0;
		dmem_arready     = 1'b0;
		dmem_rvalid      = 1'b0;
		dmem_rdata       = '0;
		dmem_awready     = 1'b0;
		dmem_wready      = 1'b0;
		dmem_bvalid      = 1'b0;
		issue_taken      = 1'b0;
		issued           = 0;
		completed        = 0;
		mismatches       = 0;
		other_errors     = 0;
		cycle_count      = 0;
		ar_seen          = 0;
		aw_seen          = 0;
		w_seen           = 0;
		ar_delay         = 0;
		aw_delay         = 0;
		w_delay          = 0;
		r_delay          = 0;
		b_delay          = 0;
		r_pending        = 1'b0;
		b_pending        = 1'b0;
		done_due         = 1'b0;
		r_addr           = '0;
		wr_addr          = '0;
		// odd multiplier keeps every byte distinct over the 64 addresses
		for (int i = 0; i < 64; i++) begin
			mem[i]       = 8'((i * 29) ^ 8'h5a);
			model_mem[i] = 8'((i * 29) ^ 8'h5a);
		end

		repeat (10) @(negedge clock);
		reset = 1'b0;
		#5;
		if (!allowin || done_valid || redirect_valid || regfile_wen || dmem_arvalid ||
				dmem_rready || dmem_awvalid || dmem_wvalid || dmem_bready) begin
			other_errors++;
			$display("outputs not idle after reset");
		end

		while (completed < num_ops && cycle_count < timeout_cycles) begin
			@(negedge clock);
			drive_bus();
			drive_issue();
			#5;
			observe();
			cycle_count++;
		end

		if (cycle_count >= timeout_cycles) begin
			other_errors++;
			$display("timeout after %0d cycles with %0d of %0d operations completed",
				cycle_count, completed, num_ops);
		end
		if (exp_q.size() != 0 || completed != issued) begin
			other_errors++;
			$display("%0d accepted operations never completed", exp_q.size());
		end
		assert_fails = u_exu_top.u_exu_assertions.fail_total;
		$display("issued %0d, completed %0d, mismatches %0d, other errors %0d, assertion fails %0d",
			issued, completed, mismatches, other_errors, assert_fails);
		if (mismatches == 0 && other_errors == 0 && assert_fails == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
design/exu_pkg.sv
design/exu_alu.sv
design/exu_ctrl.sv
design/exu_dmem_path.sv
design/exu_result.sv
design/exu_top.sv
verif/exu_assertions.sv
verif/exu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timing --top-module exu_tb -Mdir obj_dir -f files.f
./obj_dir/Vexu_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
if grep -q "^ALL CHECKS PASSED$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
